/* build.f */
+incdir+rtl
rtl/apu_pkg.sv
rtl/apu_dispatcher.sv
rtl/apu_dep_check.sv
rtl/apu_exec_unit.sv
rtl/apu_subsys_top.sv
tests/apu_tb.sv

/* tests/apu_tb.sv */
////////////////////
// Random testbench for the APU subsystem, checked each cycle against
// a model of issue, stall, hazard flags and result timing
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "apu_config.svh"

module apu_tb import apu_pkg::*; ();

  localparam int unsigned NUM_REQS    = 300;
  localparam int unsigned HOLD_LIMIT  = 200;
  localparam int unsigned DRAIN_LIMIT = 200;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        enable_i;
  apu_req_t                    req_i;
  logic [2:0][`APU_ADDR_W-1:0] read_regs_i;
  logic [2:0]                  read_regs_valid_i;
  logic [1:0][`APU_ADDR_W-1:0] write_regs_i;
  logic [1:0]                  write_regs_valid_i;
  logic                        stall_o, active_o, read_dep_o, write_dep_o;
  logic                        perf_type_o, perf_cont_o;
  apu_rsp_t                    rsp_o;

  // Accepted multi-cycle ops in acceptance order
  apu_rsp_t    exp_q[$];
  int unsigned due_q[$];
  apu_lat_e    lat_qm[$];
  apu_lat_e    last_lat = LAT_0;
  int unsigned cyc = 0;
  int unsigned n_accepted = 0;
  int unsigned n_returned = 0;
  logic        checking = 1'b0;
  int unsigned waited;

  apu_subsys_top apu_subsys_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////
  // Reference rules
  ////////////////////
  function automatic apu_lat_e class_of(input apu_op_e op);
    case (op)
      OP_ADD, OP_SUB: class_of = LAT_0;
      OP_MIN, OP_MAX: class_of = LAT_1;
      OP_MUL:         class_of = LAT_2;
      default:        class_of = LAT_MULTI;
    endcase
  endfunction

  // Cycles from accept to result valid
  function automatic int unsigned class_cycles(input apu_lat_e lat);
    case (lat)
      LAT_0:   class_cycles = 0;
      LAT_1:   class_cycles = 1;
      LAT_2:   class_cycles = 2;
      default: class_cycles = `APU_DIV_ITER + 1;
    endcase
  endfunction

  function automatic logic [`APU_DATA_W-1:0] expected_result(input apu_req_t r);
    logic [`APU_DATA_W-1:0] a, b;
    a = r.operands[0];
    b = r.operands[1];
    case (r.op)
      OP_ADD:  expected_result = a + b;
      OP_SUB:  expected_result = a - b;
      OP_MIN:  expected_result = (a < b) ? a : b;
      OP_MAX:  expected_result = (a < b) ? b : a;
      OP_MUL:  expected_result = a * b;
      // Divide by zero gives all ones
      default: expected_result = (b == '0) ? '1 : a / b;
    endcase
  endfunction

  function automatic logic read_match(input logic [`APU_ADDR_W-1:0] addr);
    read_match = 1'b0;
    for (int r = 0; r < 3; r++) begin
      read_match |= read_regs_valid_i[r] & (read_regs_i[r] == addr);
    end
  endfunction

  function automatic logic write_match(input logic [`APU_ADDR_W-1:0] addr);
    write_match = 1'b0;
    for (int w = 0; w < 2; w++) begin
      write_match |= write_regs_valid_i[w] & (write_regs_i[w] == addr);
    end
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_rsp(input apu_rsp_t got, input apu_rsp_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: rsp valid=%0b addr=%0d data=%h",
               $time, got.valid, got.waddr, got.data);
      $display("Fail at %0t: expected valid=%0b addr=%0d data=%h",
               $time, exp.valid, exp.waddr, exp.data);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0b, expected %0b", $time, name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////
  // Cycle model
  ////////////////////
  // Runs at the falling edge when inputs and outputs have settled
  task automatic model_step();
    apu_lat_e    lat_new;
    logic [1:0]  gap;
    logic        busy, div_pend, full, typ, issue, nack, accept, ret_old, ret_new;
    logic        exp_active, exp_rdep, exp_wdep;
    apu_rsp_t    exp;
    lat_new  = class_of(req_i.op);
    busy     = exp_q.size() != 0;
    div_pend = 1'b0;
    foreach (lat_qm[i]) begin
      div_pend |= (lat_qm[i] == LAT_MULTI);
    end
    full = exp_q.size() >= 2;
    gap  = last_lat - lat_new;
    // New op must not overtake live work
    // A live MUL also blocks ADD and SUB
    typ = enable_i & busy &
          ((lat_new == LAT_1) | (lat_new == LAT_MULTI) | (gap == 2'd1) |
           ((last_lat == LAT_2) & (lat_new == LAT_0)));
    issue   = enable_i & ~full & ~typ;
    nack    = issue & div_pend;
    accept  = issue & ~div_pend;
    ret_old = busy && (due_q[0] == cyc);
    ret_new = accept & (lat_new == LAT_0);
    exp     = '{valid: 1'b1, waddr: req_i.waddr, data: expected_result(req_i)};
    if (ret_old) begin
      check_rsp(rsp_o, exp_q[0]);
    end else if (ret_new) begin
      check_rsp(rsp_o, exp);
    end else begin
      check_flag(rsp_o.valid, 1'b0, "rsp valid");
    end
    // Live destinations exclude anything returning now
    exp_active = 1'b0;
    exp_rdep   = 1'b0;
    exp_wdep   = 1'b0;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (due_q[i] != cyc) begin
        exp_active = 1'b1;
        exp_rdep  |= read_match(exp_q[i].waddr);
        exp_wdep  |= write_match(exp_q[i].waddr);
      end
    end
    if (issue & ~ret_new) begin
      exp_rdep |= read_match(req_i.waddr);
      exp_wdep |= write_match(req_i.waddr);
    end
    check_flag(stall_o, full | typ | nack, "stall");
    check_flag(active_o, exp_active, "active");
    check_flag(read_dep_o, exp_rdep, "read dep");
    check_flag(write_dep_o, exp_wdep, "write dep");
    check_flag(perf_type_o, typ, "perf type");
    check_flag(perf_cont_o, nack, "perf cont");
    if (ret_old) begin
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
      void'(lat_qm.pop_front());
      n_returned++;
    end
    if (ret_new) begin
      n_returned++;
    end
    if (accept) begin
      n_accepted++;
      last_lat = lat_new;
      if (lat_new != LAT_0) begin
        exp_q.push_back(exp);
        due_q.push_back(cyc + class_cycles(lat_new));
        lat_qm.push_back(lat_new);
      end
    end
    cyc++;
  endtask

  initial begin
    forever begin
      @(negedge clk_i);
      if (checking) begin
        model_step();
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  // Small address range so hazards show up often
  task automatic drive_regs();
    for (int r = 0; r < 3; r++) begin
      read_regs_i[r] = $urandom_range(7);
    end
    for (int w = 0; w < 2; w++) begin
      write_regs_i[w] = $urandom_range(7);
    end
    read_regs_valid_i  = $urandom_range(7);
    write_regs_valid_i = $urandom_range(3);
  endtask

  // Holds the request until a cycle without stall accepts it
  task automatic issue_request();
    int unsigned held;
    req_i.op          = apu_op_e'($urandom_range(5));
    req_i.operands[0] = $urandom;
    if ($urandom_range(7) == 0) begin
      req_i.operands[1] = '0;
    end else begin
      req_i.operands[1] = $urandom >> $urandom_range(31);
    end
    req_i.waddr = $urandom_range(7);
    enable_i    = 1'b1;
    drive_regs();
    held = 0;
    @(negedge clk_i);
    while (stall_o) begin
      if (held >= HOLD_LIMIT) begin
        $display("Timeout: request still stalled after %0d cycles", held);
        abort_run();
      end else begin
        held++;
        @(posedge clk_i);
        #2;
        drive_regs();
        @(negedge clk_i);
      end
    end
    @(posedge clk_i);
    #2;
    enable_i = 1'b0;
    drive_regs();
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
      drive_regs();
    end
  endtask

  initial begin
    void'($urandom(32'h938b));
    rst_ni             = 1'b0;
    enable_i           = 1'b0;
    req_i              = '0;
    read_regs_i        = '0;
    read_regs_valid_i  = '0;
    write_regs_i       = '0;
    write_regs_valid_i = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni   = 1'b1;
    checking = 1'b1;
    for (int n = 0; n < NUM_REQS; n++) begin
      issue_request();
      idle_cycles($urandom_range(2));
    end
    // Drain outstanding results
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= DRAIN_LIMIT) begin
        $display("Timeout: results still outstanding after the last request");
        abort_run();
      end else begin
        waited++;
        @(posedge clk_i);
        #2;
        drive_regs();
      end
    end
    @(negedge clk_i);
    if ((n_accepted != n_returned) || (n_accepted != NUM_REQS)) begin
      $display("Fail at %0t: %0d accepted and %0d returned of %0d requests",
               $time, n_accepted, n_returned, NUM_REQS);
      abort_run();
    end else begin
      $display("%0d requests accepted and returned", n_accepted);
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* rtl/apu_subsys_top.sv */
////////////////////
// APU subsystem top: dispatcher, hazard check and execution unit
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "apu_config.svh"

module apu_subsys_top import apu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        enable_i,
  input  apu_req_t                    req_i,
  input  logic [2:0][`APU_ADDR_W-1:0] read_regs_i,
  input  logic [2:0]                  read_regs_valid_i,
  input  logic [1:0][`APU_ADDR_W-1:0] write_regs_i,
  input  logic [1:0]                  write_regs_valid_i,
  output logic                        stall_o,
  output logic                        active_o,
  output logic                        read_dep_o,
  output logic                        write_dep_o,
  output apu_rsp_t                    rsp_o,
  output logic                        perf_type_o,
  output logic                        perf_cont_o
);

  logic                   issue, gnt, res_valid;
  logic [`APU_DATA_W-1:0] res_data;
  logic [`APU_ADDR_W-1:0] rsp_waddr;
  apu_slot_t              slot_req, slot_inflight, slot_waiting;

  apu_dispatcher apu_dispatcher_i (
    .clk_i, .rst_ni, .enable_i,
    .op_i           (req_i.op),
    .waddr_i        (req_i.waddr),
    .gnt_i          (gnt),
    .res_valid_i    (res_valid),
    .issue_o        (issue),
    .stall_o, .active_o,
    .rsp_waddr_o    (rsp_waddr),
    .slot_req_o     (slot_req),
    .slot_inflight_o(slot_inflight),
    .slot_waiting_o (slot_waiting),
    .perf_type_o, .perf_cont_o
  );

  apu_dep_check apu_dep_check_i (
    .slot_req_i     (slot_req),
    .slot_inflight_i(slot_inflight),
    .slot_waiting_i (slot_waiting),
    .read_regs_i, .read_regs_valid_i,
    .write_regs_i, .write_regs_valid_i,
    .read_dep_o, .write_dep_o
  );

  apu_exec_unit apu_exec_unit_i (
    .clk_i, .rst_ni,
    .issue_i    (issue),
    .req_i,
    .gnt_o      (gnt),
    .res_valid_o(res_valid),
    .res_data_o (res_data)
  );

  // Result data from the datapath, address from the dispatcher
  assign rsp_o = '{valid: res_valid, waddr: rsp_waddr, data: res_data};

endmodule

`default_nettype wire

/* rtl/apu_exec_unit.sv */
////////////////////
// APU datapath with add/sub, min/max, pipelined multiply and an
// iterative unsigned divider, one result per cycle at most
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "apu_config.svh"

module apu_exec_unit import apu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   issue_i,
  input  apu_req_t               req_i,
  output logic                   gnt_o,
  output logic                   res_valid_o,
  output logic [`APU_DATA_W-1:0] res_data_o
);

  localparam int unsigned W     = `APU_DATA_W;
  localparam int unsigned H     = W / 2;
  localparam int unsigned CNT_W = $clog2(`APU_DIV_ITER + 1);

  // Divider sequencing, DONE is the result cycle
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
  } div_state_e;

  logic [W-1:0] op_a, op_b;
  apu_lat_e     lat;
  logic         accept;
  logic         add_valid;
  logic [W-1:0] add_res;
  logic         a_lt_b;
  logic         mm_valid_q;
  logic [W-1:0] mm_res_q;
  logic         mul_v1_q, mul_v2_q;
  logic [W-1:0] mul_lo_q, mul_hi_q, mul_res_q;
  div_state_e   div_state_q;
  logic [CNT_W-1:0] div_cnt_q;
  logic [W-1:0] div_quo_q, div_rem_q, div_dsr_q;
  logic [W:0]   div_shift, div_diff;
  logic         div_done;

  assign op_a   = req_i.operands[0];
  assign op_b   = req_i.operands[1];
  assign lat    = op_latency(req_i.op);
  // Only the divider can refuse work
  assign gnt_o  = (div_state_q == DIV_IDLE);
  assign accept = issue_i & gnt_o;

  ////////////////////
  // Add and subtract
  ////////////////////
  assign add_valid = accept & (lat == LAT_0);
  assign add_res   = (req_i.op == OP_SUB) ? op_a - op_b : op_a + op_b;

  // Unsigned min/max, one register stage
  assign a_lt_b = op_a < op_b;

  always_ff @(posedge clk_i) begin
    if (accept & (lat == LAT_1)) begin
      if (req_i.op == OP_MIN) begin
        mm_res_q <= a_lt_b ? op_a : op_b;
      end else begin
        mm_res_q <= a_lt_b ? op_b : op_a;
      end
    end
  end

  ////////////////////
  // Multiplier
  ////////////////////
  // Stage 1 forms two half-width partial products, stage 2 sums them
  always_ff @(posedge clk_i) begin
    if (accept & (lat == LAT_2)) begin
      mul_lo_q <= op_a * {{H{1'b0}}, op_b[H-1:0]};
      mul_hi_q <= op_a * {{H{1'b0}}, op_b[W-1:H]};
    end
    if (mul_v1_q) begin
      mul_res_q <= mul_lo_q + (mul_hi_q << H);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mm_valid_q <= 1'b0;
      mul_v1_q   <= 1'b0;
      mul_v2_q   <= 1'b0;
    end else begin
      mm_valid_q <= accept & (lat == LAT_1);
      mul_v1_q   <= accept & (lat == LAT_2);
      mul_v2_q   <= mul_v1_q;
    end
  end

  ////////////////////
  // Divider
  ////////////////////
  // Restoring division, one quotient bit per cycle, MSB first
  // Zero divisor always subtracts, so the quotient ends as all ones
  assign div_shift = {div_rem_q, div_quo_q[W-1]};
  assign div_diff  = div_shift - {1'b0, div_dsr_q};
  assign div_done  = (div_state_q == DIV_DONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_state_q <= DIV_IDLE;
      div_cnt_q   <= '0;
    end else begin
      case (div_state_q)
        DIV_IDLE: begin
          if (accept & (lat == LAT_MULTI)) begin
            div_state_q <= DIV_BUSY;
            div_cnt_q   <= CNT_W'(`APU_DIV_ITER);
          end
        end
        DIV_BUSY: begin
          div_cnt_q <= div_cnt_q - 1'b1;
          // Last step, result shows next cycle
          if (div_cnt_q == CNT_W'(1)) begin
            div_state_q <= DIV_DONE;
          end
        end
        default: div_state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept & (lat == LAT_MULTI)) begin
      div_quo_q <= op_a;
      div_rem_q <= '0;
      div_dsr_q <= op_b;
    end else if (div_state_q == DIV_BUSY) begin
      // Negative difference keeps the shifted remainder
      if (!div_diff[W]) begin
        div_rem_q <= div_diff[W-1:0];
        div_quo_q <= {div_quo_q[W-2:0], 1'b1};
      end else begin
        div_rem_q <= div_shift[W-1:0];
        div_quo_q <= {div_quo_q[W-2:0], 1'b0};
      end
    end
  end

  // Result select, the issue rules keep the paths apart
  assign res_valid_o = add_valid | mm_valid_q | mul_v2_q | div_done;

  always_comb begin
    res_data_o = add_res;
    if (mm_valid_q) begin
      res_data_o = mm_res_q;
    end else if (mul_v2_q) begin
      res_data_o = mul_res_q;
    end else if (div_done) begin
      res_data_o = div_quo_q;
    end
  end

  // Dispatcher stall rule must prevent result collisions
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({add_valid, mm_valid_q, mul_v2_q, div_done}))
    else $error("APU result paths collide");

endmodule

`default_nettype wire

/* rtl/apu_dep_check.sv */
////////////////////
// Read and write hazard check of core register addresses
// against the live APU destinations
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "apu_config.svh"

module apu_dep_check import apu_pkg::*; (
  input  apu_slot_t                   slot_req_i,
  input  apu_slot_t                   slot_inflight_i,
  input  apu_slot_t                   slot_waiting_i,
  // Source operands of the instruction in decode
  input  logic [2:0][`APU_ADDR_W-1:0] read_regs_i,
  input  logic [2:0]                  read_regs_valid_i,
  // Destinations of the instruction in decode
  input  logic [1:0][`APU_ADDR_W-1:0] write_regs_i,
  input  logic [1:0]                  write_regs_valid_i,
  output logic                        read_dep_o,
  output logic                        write_dep_o
);

  apu_slot_t [2:0]       slots;
  // Hit matrices indexed by slot, then by register port
  logic      [2:0][2:0]  read_hits;
  logic      [2:0][1:0]  write_hits;

  assign slots = {slot_waiting_i, slot_inflight_i, slot_req_i};

  for (genvar s = 0; s < 3; s++) begin : g_slot
    // RAW on pending results
    for (genvar r = 0; r < 3; r++) begin : g_read
      assign read_hits[s][r] = slots[s].live & read_regs_valid_i[r] &
                               (read_regs_i[r] == slots[s].addr);
    end
    // WAW on pending results
    for (genvar w = 0; w < 2; w++) begin : g_write
      assign write_hits[s][w] = slots[s].live & write_regs_valid_i[w] &
                                (write_regs_i[w] == slots[s].addr);
    end
  end

  assign read_dep_o  = |read_hits;
  assign write_dep_o = |write_hits;

endmodule

`default_nettype wire

/* rtl/apu_dispatcher.sv */
////////////////////
// Issue control for the APU: tracks unreturned work, stalls the core
// and steers each returning result to its destination register
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "apu_config.svh"

module apu_dispatcher import apu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Core request side
  input  logic                   enable_i,
  input  apu_op_e                op_i,
  input  logic [`APU_ADDR_W-1:0] waddr_i,
  // Execution unit handshake
  input  logic                   gnt_i,
  input  logic                   res_valid_i,
  output logic                   issue_o,
  // Core status
  output logic                   stall_o,
  output logic                   active_o,
  output logic [`APU_ADDR_W-1:0] rsp_waddr_o,
  // Live destinations for the dependency checker
  output apu_slot_t              slot_req_o,
  output apu_slot_t              slot_inflight_o,
  output apu_slot_t              slot_waiting_o,
  // Performance events
  output logic                   perf_type_o,
  output logic                   perf_cont_o
);

  apu_slot_t  inflight_q, inflight_d;
  apu_slot_t  waiting_q, waiting_d;
  apu_lat_e   lat_new, lat_q;
  logic [1:0] lat_gap;
  logic       busy;
  logic       req_accepted;
  logic       returned_req, returned_inflight, returned_waiting;
  logic       stall_full, stall_type, stall_nack;

  assign lat_new = op_latency(op_i);
  // Some registered slot still waits for its result
  assign busy    = inflight_q.live | waiting_q.live;

  ////////////////////
  // Stall causes
  ////////////////////
  // No room for another multi-cycle entry
  assign stall_full = inflight_q.live & waiting_q.live;
  assign lat_gap    = lat_q - lat_new;
  // New op would overtake or collide with live work
  // Last case: a live MUL always returns after an ADD issued now
  assign stall_type = enable_i & busy &
                      ((lat_new == LAT_1) | (lat_new == LAT_MULTI) | (lat_gap == 2'd1) |
                       ((lat_q == LAT_2) & (lat_new == LAT_0)));
  assign issue_o      = enable_i & ~(stall_full | stall_type);
  // Issued but refused, divider still busy
  assign stall_nack   = issue_o & ~gnt_i;
  assign stall_o      = stall_full | stall_type | stall_nack;
  assign req_accepted = issue_o & gnt_i;

  ////////////////////
  // Return detection
  ////////////////////
  // Results come back in order, the oldest live entry owns the result
  assign returned_req      = req_accepted & res_valid_i & ~busy;
  assign returned_inflight = inflight_q.live & res_valid_i & ~waiting_q.live;
  assign returned_waiting  = waiting_q.live & res_valid_i;

  // Slot update on accept and return
  always_comb begin
    inflight_d = inflight_q;
    waiting_d  = waiting_q;
    if (req_accepted & ~returned_req) begin
      // Multi-cycle request enters the in-flight slot
      inflight_d = '{live: 1'b1, addr: waddr_i};
      // Older entry still out, shift it to waiting
      if (inflight_q.live & ~returned_inflight) begin
        waiting_d = inflight_q;
      end
    end else if (returned_inflight) begin
      inflight_d = '0;
    end else if (returned_waiting) begin
      waiting_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
      waiting_q  <= '0;
    end else begin
      inflight_q <= inflight_d;
      waiting_q  <= waiting_d;
    end
  end

  // Class of the last accepted op, compared against the next one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_q <= LAT_0;
    end else if (req_accepted) begin
      lat_q <= lat_new;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////
  // Entries returning this cycle are already dropped
  assign slot_req_o      = '{live: issue_o & ~returned_req, addr: waddr_i};
  assign slot_inflight_o = '{live: inflight_q.live & ~returned_inflight, addr: inflight_q.addr};
  assign slot_waiting_o  = '{live: waiting_q.live & ~returned_waiting, addr: waiting_q.addr};
  assign active_o        = slot_inflight_o.live | slot_waiting_o.live;

  // Destination of the result, oldest entry first
  always_comb begin
    rsp_waddr_o = '0;
    if (returned_waiting) begin
      rsp_waddr_o = waiting_q.addr;
    end else if (returned_inflight) begin
      rsp_waddr_o = inflight_q.addr;
    end else if (returned_req) begin
      rsp_waddr_o = waddr_i;
    end
  end

  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  ////////////////////
  // Assertions
  ////////////////////
  // Execution unit only answers work the dispatcher knows about
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i |-> (req_accepted | busy))
    else $error("APU result returned with nothing in flight");

  // Waiting entry is always older than a live in-flight entry
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    waiting_q.live |-> inflight_q.live)
    else $error("APU waiting slot live without in-flight slot");

endmodule

`default_nettype wire

/* rtl/apu_pkg.sv */
////////////////////
// Opcode, latency and bus struct types shared by all APU blocks
////////////////////
`default_nettype none

`include "apu_config.svh"

package apu_pkg;

  // Operations offered by the execution unit
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_MIN,
    OP_MAX,
    OP_MUL,
    OP_DIVU
  } apu_op_e;

  // Latency class, LAT_MULTI is the iterative divider
  typedef enum logic [1:0] {
    LAT_0,
    LAT_1,
    LAT_2,
    LAT_MULTI
  } apu_lat_e;

  // Request from the core, held stable while stalled
  typedef struct packed {
    apu_op_e                                      op;
    logic [`APU_NARGS-1:0][`APU_DATA_W-1:0]       operands;
    logic [`APU_ADDR_W-1:0]                       waddr;
  } apu_req_t;

  // Result back to the core register file
  typedef struct packed {
    logic                   valid;
    logic [`APU_ADDR_W-1:0] waddr;
    logic [`APU_DATA_W-1:0] data;
  } apu_rsp_t;

  // One tracked destination
  typedef struct packed {
    logic                   live;
    logic [`APU_ADDR_W-1:0] addr;
  } apu_slot_t;

  // Cycles from accept to result, by opcode
  function automatic apu_lat_e op_latency(input apu_op_e op);
    case (op)
      OP_ADD, OP_SUB: return LAT_0;
      OP_MIN, OP_MAX: return LAT_1;
      OP_MUL:         return LAT_2;
      default:        return LAT_MULTI;
    endcase
  endfunction

endpackage

`default_nettype wire

/* rtl/apu_config.svh */
////////////////////
// Width and iteration constants for the APU subsystem
// Included by the package, the RTL and the testbench
////////////////////
`ifndef APU_CONFIG_SVH
`define APU_CONFIG_SVH

// Core register address width
`define APU_ADDR_W 6

// Operand and result width
`define APU_DATA_W 32

// Operands carried by one request
`define APU_NARGS 2

// Shift-subtract steps of the divider, one per cycle
`define APU_DIV_ITER 32

`endif
